/* run.sh */
#!/bin/sh
# Build and run the NTT controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module ntt_ctrl_tb -f verilog.f -o ntt_ctrl_sim
./obj_dir/ntt_ctrl_sim

/* source/ntt_ctrl.sv */
`timescale 1ns/100ps

module ntt_ctrl
    import ntt_ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize,
    input  logic           ntt_enable,
    input  logic           butterfly_ready,
    input  ntt_base_addr_t base_addr,
    output mem_req_t       mem_rd,
    output mem_req_t       mem_wr,
    output twiddle_addr_t  twiddle_addr,
    output logic           bf_enable,
    output logic           busy,
    output logic           done
);

    // Round hand-off between the sequencers
    logic        round_start;
    round_info_t round_info;
    logic        rd_round_done;
    logic        wr_round_done;

    // Steps rounds and picks the bases
    ntt_round_ctrl round_ctrl_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .ntt_enable    (ntt_enable),
        .base_addr     (base_addr),
        .rd_round_done (rd_round_done),
        .wr_round_done (wr_round_done),
        .round_start   (round_start),
        .round_info    (round_info),
        .busy          (busy),
        .done          (done)
    );

    // Producer side, stride-16 reads and twiddles
    ntt_read_seq read_seq_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .round_start   (round_start),
        .round_info    (round_info),
        .mem_rd        (mem_rd),
        .twiddle_addr  (twiddle_addr),
        .bf_enable     (bf_enable),
        .rd_round_done (rd_round_done)
    );

    // Consumer side, writes paced by the butterfly
    ntt_write_seq write_seq_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize         (zeroize),
        .round_start     (round_start),
        .round_info      (round_info),
        .butterfly_ready (butterfly_ready),
        .mem_wr          (mem_wr),
        .wr_round_done   (wr_round_done)
    );

endmodule

/* source/ntt_ctrl_pkg.sv */
package ntt_ctrl_pkg;

    // ----------------------------------------
    // Sizes and strides
    // ----------------------------------------
    localparam int MEM_ADDR_WIDTH      = 15;
    localparam int TWIDDLE_ADDR_WIDTH  = 7;
    // 256 coefficients packed four per word
    localparam int NTT_WORDS_PER_ROUND = 64;
    localparam int NTT_NUM_ROUNDS      = 4;
    // Column stride of the forward read order
    localparam int NTT_READ_ADDR_STEP  = 16;

    typedef logic [MEM_ADDR_WIDTH-1:0]     mem_addr_t;
    typedef logic [TWIDDLE_ADDR_WIDTH-1:0] twiddle_addr_t;
    // One spare code so the count can reach NTT_NUM_ROUNDS
    typedef logic [2:0]                    round_t;

    // ----------------------------------------
    // Bundles
    // ----------------------------------------
    typedef struct packed {
        mem_addr_t src_base_addr;
        mem_addr_t interim_base_addr;
        mem_addr_t dest_base_addr;
    } ntt_base_addr_t;

    // Strobe plus word address, same shape for read and write
    typedef struct packed {
        logic      en;
        mem_addr_t addr;
    } mem_req_t;

    // Handed to both sequencers while round_start is high
    typedef struct packed {
        round_t    round;
        mem_addr_t rd_base;
        mem_addr_t wr_base;
    } round_info_t;

    typedef enum logic [1:0] {RC_IDLE, RC_START, RC_RUN, RC_DONE} round_state_t;
    typedef enum logic {RD_IDLE, RD_EXEC} rd_state_t;
    typedef enum logic {WR_IDLE, WR_MEM} wr_state_t;

endpackage

/* source/ntt_read_seq.sv */
`timescale 1ns/100ps

module ntt_read_seq
    import ntt_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,
    input  logic          zeroize,
    input  logic          round_start,
    input  round_info_t   round_info,
    output mem_req_t      mem_rd,
    output twiddle_addr_t twiddle_addr,
    output logic          bf_enable,
    output logic          rd_round_done
);

    // Step back from the bottom of a column to the top of the next one
    localparam mem_addr_t ADDR_STEP = mem_addr_t'(NTT_READ_ADDR_STEP);
    localparam mem_addr_t ADDR_WRAP = mem_addr_t'(NTT_WORDS_PER_ROUND - 1 - NTT_READ_ADDR_STEP);

    rd_state_t  state;
    logic [5:0] rd_count;
    mem_addr_t  rd_addr;
    round_t     rd_round;
    logic       last_read;
    logic       wrap;

    assign last_read = (state == RD_EXEC) && (rd_count == 6'(NTT_WORDS_PER_ROUND - 1));
    // Every fourth read leaves the column, e.g. 48 goes to 1
    assign wrap      = (rd_count[1:0] == 2'd3);

    // ----------------------------------------
    // Read FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= RD_IDLE;
            rd_count      <= '0;
            rd_round      <= '0;
            bf_enable     <= 1'b0;
            rd_round_done <= 1'b0;
        end else if (zeroize) begin
            state         <= RD_IDLE;
            rd_count      <= '0;
            rd_round      <= '0;
            bf_enable     <= 1'b0;
            rd_round_done <= 1'b0;
        end else begin
            // Read data reaches the butterfly one cycle later
            bf_enable     <= mem_rd.en;
            rd_round_done <= last_read;
            if ((state == RD_IDLE) && round_start) begin
                state    <= RD_EXEC;
                rd_count <= '0;
                rd_round <= round_info.round;
            end else if (state == RD_EXEC) begin
                rd_count <= rd_count + 6'd1;
                if (last_read) begin
                    state <= RD_IDLE;
                end
            end
        end
    end

    // Address register
    always_ff @(posedge clk) begin
        if ((state == RD_IDLE) && round_start) begin
            rd_addr <= round_info.rd_base;
        end else if (state == RD_EXEC) begin
            rd_addr <= wrap ? rd_addr - ADDR_WRAP : rd_addr + ADDR_STEP;
        end
    end

    always_comb begin
        mem_rd.en   = (state == RD_EXEC);
        mem_rd.addr = rd_addr;
    end

    // Twiddle index advances with every read strobe
    ntt_twiddle_addr_gen twiddle_gen_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .round        (rd_round),
        .clear        (round_start),
        .step         (mem_rd.en),
        .twiddle_addr (twiddle_addr)
    );

endmodule

/* source/ntt_round_ctrl.sv */
`timescale 1ns/100ps

module ntt_round_ctrl
    import ntt_ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize,
    input  logic           ntt_enable,
    input  ntt_base_addr_t base_addr,
    input  logic           rd_round_done,
    input  logic           wr_round_done,
    output logic           round_start,
    output round_info_t    round_info,
    output logic           busy,
    output logic           done
);

    round_state_t state;
    round_state_t state_nxt;
    round_t       round;
    logic         rd_done_seen;
    logic         wr_done_seen;
    logic         both_done;
    logic         last_round;

    // A done pulse counts in the same cycle it arrives
    assign both_done  = (rd_done_seen || rd_round_done) && (wr_done_seen || wr_round_done);
    assign last_round = (round == round_t'(NTT_NUM_ROUNDS - 1));

    // ----------------------------------------
    // Round FSM
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        unique case (state)
            RC_IDLE: begin
                // Start strobe is only looked at here
                if (ntt_enable) begin
                    state_nxt = RC_START;
                end
            end
            RC_START: begin
                state_nxt = RC_RUN;
            end
            RC_RUN: begin
                if (both_done) begin
                    state_nxt = last_round ? RC_DONE : RC_START;
                end
            end
            default: begin
                state_nxt = RC_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= RC_IDLE;
            round        <= '0;
            rd_done_seen <= 1'b0;
            wr_done_seen <= 1'b0;
        end else if (zeroize) begin
            state        <= RC_IDLE;
            round        <= '0;
            rd_done_seen <= 1'b0;
            wr_done_seen <= 1'b0;
        end else begin
            state <= state_nxt;
            if ((state == RC_RUN) && both_done) begin
                // Round closed, flags rearm for the next one
                round        <= round + round_t'(1);
                rd_done_seen <= 1'b0;
                wr_done_seen <= 1'b0;
            end else begin
                rd_done_seen <= rd_done_seen || rd_round_done;
                wr_done_seen <= wr_done_seen || wr_round_done;
            end
            if (state == RC_DONE) begin
                round <= '0;
            end
        end
    end

    // ----------------------------------------
    // Ping-pong base selection
    // ----------------------------------------
    always_comb begin
        round_info.round   = round;
        // Source first, then interim and dest take turns
        round_info.rd_base = (round == '0) ? base_addr.src_base_addr :
                             round[0]      ? base_addr.interim_base_addr :
                                             base_addr.dest_base_addr;
        round_info.wr_base = round[0] ? base_addr.dest_base_addr : base_addr.interim_base_addr;
    end

    assign round_start = (state == RC_START);
    // Busy drops in the done cycle
    assign busy        = (state == RC_START) || (state == RC_RUN);
    assign done        = (state == RC_DONE);

endmodule

/* source/ntt_twiddle_addr_gen.sv */
`timescale 1ns/100ps

module ntt_twiddle_addr_gen
    import ntt_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,
    input  logic          zeroize,
    input  round_t        round,
    input  logic          clear,
    input  logic          step,
    output twiddle_addr_t twiddle_addr
);

    twiddle_addr_t count;
    twiddle_addr_t span;
    twiddle_addr_t offset;

    // Offset of each round's twiddle block in the ROM, and its last index
    always_comb begin
        unique case (round)
            3'd0: begin
                span   = 7'd0;
                offset = 7'd0;
            end
            3'd1: begin
                span   = 7'd3;
                offset = 7'd1;
            end
            3'd2: begin
                span   = 7'd15;
                offset = 7'd5;
            end
            3'd3: begin
                span   = 7'd63;
                offset = 7'd21;
            end
            default: begin
                span   = 7'd0;
                offset = 7'd0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (zeroize || clear) begin
            count <= '0;
        end else if (step) begin
            // Wrap back to the block start after the span
            count <= (count == span) ? '0 : count + 7'd1;
        end
    end

    assign twiddle_addr = count + offset;

endmodule

/* source/ntt_write_seq.sv */
`timescale 1ns/100ps

module ntt_write_seq
    import ntt_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        zeroize,
    input  logic        round_start,
    input  round_info_t round_info,
    input  logic        butterfly_ready,
    output mem_req_t    mem_wr,
    output logic        wr_round_done
);

    wr_state_t  state;
    logic [5:0] wr_count;
    mem_addr_t  wr_addr;
    logic       wr_en;

    // One write per butterfly result, only inside a round
    assign wr_en         = (state == WR_MEM) && butterfly_ready;
    // Flagged on the 64th write itself
    assign wr_round_done = wr_en && (wr_count == 6'(NTT_WORDS_PER_ROUND - 1));

    // ----------------------------------------
    // Write FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= WR_IDLE;
            wr_count <= '0;
        end else if (zeroize) begin
            state    <= WR_IDLE;
            wr_count <= '0;
        end else if ((state == WR_IDLE) && round_start) begin
            state    <= WR_MEM;
            wr_count <= '0;
        end else if (wr_en) begin
            wr_count <= wr_count + 6'd1;
            if (wr_round_done) begin
                state <= WR_IDLE;
            end
        end
    end

    // Consecutive addresses from the round's write base
    always_ff @(posedge clk) begin
        if ((state == WR_IDLE) && round_start) begin
            wr_addr <= round_info.wr_base;
        end else if (wr_en) begin
            wr_addr <= wr_addr + mem_addr_t'(1);
        end
    end

    always_comb begin
        mem_wr.en   = wr_en;
        mem_wr.addr = wr_addr;
    end

endmodule

/* tests/ntt_ctrl_checker.sv */
`timescale 1ns/100ps

module ntt_ctrl_checker
    import ntt_ctrl_pkg::*;
(
    input logic     clk,
    input logic     reset_n,
    input logic     zeroize,
    input mem_req_t mem_rd,
    input mem_req_t mem_wr,
    input logic     bf_enable,
    input logic     busy,
    input logic     done
);

    // ----------------------------------------
    // Port protocol
    // ----------------------------------------

    // Butterfly enable trails the read strobe, zeroize clears both at once
    bf_follows_read: assert property (@(posedge clk) disable iff (!reset_n)
        !$past(zeroize) |-> (bf_enable == $past(mem_rd.en)))
        else $error("bf_enable is not mem_rd.en delayed by one cycle");

    done_single: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> !done)
        else $error("done stays high for more than one cycle");

    // Memory is touched only inside a run
    no_strobe_idle: assert property (@(posedge clk) disable iff (!reset_n)
        !busy |-> !(mem_rd.en || mem_wr.en))
        else $error("memory strobe while busy is low");

    quiet_in_reset: assert property (@(posedge clk)
        !reset_n |-> !(mem_rd.en || mem_wr.en || bf_enable || busy || done))
        else $error("control output high during reset");

endmodule

bind ntt_ctrl ntt_ctrl_checker checker_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .bf_enable (bf_enable),
    .busy      (busy),
    .done      (done)
);

/* tests/ntt_ctrl_tb.sv */
`timescale 1ns/100ps

module ntt_ctrl_tb
    import ntt_ctrl_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    // Three full runs and one cut short by zeroize
    localparam int NUM_RUNS    = 4;
    // Twiddle block start and last index per round
    localparam int TW_OFFSET [4] = '{0, 1, 5, 21};
    localparam int TW_SPAN   [4] = '{0, 3, 15, 63};
    localparam ntt_base_addr_t BASES_A = '{15'h0000, 15'h0100, 15'h0200};
    localparam ntt_base_addr_t BASES_B = '{15'h1040, 15'h2080, 15'h30c0};
    localparam ntt_base_addr_t BASES_C = '{15'h0400, 15'h0500, 15'h0600};

    typedef struct packed {
        mem_addr_t     rd_addr;
        mem_addr_t     wr_addr;
        twiddle_addr_t tw_addr;
    } expect_t;

    logic           clk;
    logic           reset_n;
    logic           zeroize;
    logic           ntt_enable;
    logic           butterfly_ready;
    ntt_base_addr_t base_addr;
    mem_req_t       mem_rd;
    mem_req_t       mem_wr;
    twiddle_addr_t  twiddle_addr;
    logic           bf_enable;
    logic           busy;
    logic           done;

    string  test_name;
    logic   expect_quiet;
    // Progress of the running NTT, written by the compare process only
    round_t cur_round  = '0;
    int     rd_idx     = 0;
    int     wr_idx     = 0;
    int     wr_total   = 0;
    int     done_count = 0;

    // Cycle numbers at which pending butterfly results come back
    int ready_due[$];

    ntt_ctrl ntt_ctrl_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize         (zeroize),
        .ntt_enable      (ntt_enable),
        .butterfly_ready (butterfly_ready),
        .base_addr       (base_addr),
        .mem_rd          (mem_rd),
        .mem_wr          (mem_wr),
        .twiddle_addr    (twiddle_addr),
        .bf_enable       (bf_enable),
        .busy            (busy),
        .done            (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Whole budget for all runs, far above the real length
    initial begin
        #(NUM_RUNS * NTT_NUM_ROUNDS * 200 * CLK_PERIOD);
        fail_run("Timeout: the NTT runs did not finish in the expected time");
    end

    // ----------------------------------------
    // Reference and compare tasks
    // ----------------------------------------
    function automatic expect_t ref_addrs(input round_t r, input int k, input ntt_base_addr_t b);
        expect_t   e;
        mem_addr_t rd_base;
        mem_addr_t wr_base;
        if (r == 3'd0) rd_base = b.src_base_addr;
        else if (r == 3'd2) rd_base = b.dest_base_addr;
        else rd_base = b.interim_base_addr;
        // Rounds 1 and 3 write dest, rounds 0 and 2 write interim
        wr_base   = ((r == 3'd1) || (r == 3'd3)) ? b.dest_base_addr : b.interim_base_addr;
        // Four columns of stride 16, then one word on
        e.rd_addr = rd_base + mem_addr_t'(NTT_READ_ADDR_STEP * (k % 4) + k / 4);
        e.wr_addr = wr_base + mem_addr_t'(k);
        e.tw_addr = twiddle_addr_t'(TW_OFFSET[r[1:0]] + k % (TW_SPAN[r[1:0]] + 1));
        return e;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic check_addr(input string what, input mem_addr_t expected, input mem_addr_t actual);
        if (expected !== actual) begin
            fail_run($sformatf("Error in %s: %s expected 'h%0h actual 'h%0h",
                               test_name, what, expected, actual));
        end
    endtask

    task automatic check_twiddle(input string what, input twiddle_addr_t expected,
                                 input twiddle_addr_t actual);
        if (expected !== actual) begin
            fail_run($sformatf("Error in %s: %s expected %0d actual %0d",
                               test_name, what, expected, actual));
        end
    endtask

    task automatic check_round(input string what, input round_t expected, input round_t actual);
        if (expected !== actual) begin
            fail_run($sformatf("Error in %s: %s expected %0d actual %0d",
                               test_name, what, expected, actual));
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        if (expected != actual) begin
            fail_run($sformatf("Error in %s: %s expected %0d actual %0d",
                               test_name, what, expected, actual));
        end
    endtask

    // ----------------------------------------
    // Butterfly model
    // ----------------------------------------
    initial begin : butterfly_model
        integer seed;
        int     cycle_count;
        int     due;
        seed        = 32'he26c1cf5;
        cycle_count = 0;
        forever begin
            @(negedge clk);
            if (bf_enable) begin
                due = cycle_count + 2 + ($unsigned($random(seed)) % 4);
                // Keep results in order, one per cycle at most
                if ((ready_due.size() > 0) && (due <= ready_due[$])) due = ready_due[$] + 1;
                ready_due.push_back(due);
            end
            @(posedge clk);
            cycle_count = cycle_count + 1;
            if (zeroize) ready_due.delete();
            #DRIVE_DELAY;
            if ((ready_due.size() > 0) && (ready_due[0] == cycle_count)) begin
                butterfly_ready = 1'b1;
                void'(ready_due.pop_front());
            end else begin
                butterfly_ready = 1'b0;
            end
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin : compare_outputs
        expect_t exp_addr;
        if (ntt_enable && !busy) begin
            // Accepted start, tracking begins at round 0
            cur_round  = '0;
            rd_idx     = 0;
            wr_idx     = 0;
            wr_total   = 0;
            done_count = 0;
        end
        if (reset_n && expect_quiet) begin
            if (mem_rd.en || mem_wr.en || bf_enable || done) begin
                fail_run("A strobe or done pulse appeared after zeroize");
            end
        end else if (reset_n) begin
            if (mem_rd.en) begin
                if (rd_idx >= NTT_WORDS_PER_ROUND) fail_run("More than 64 reads in one round");
                exp_addr = ref_addrs(cur_round, rd_idx, base_addr);
                check_addr("read address", exp_addr.rd_addr, mem_rd.addr);
                check_twiddle("twiddle address", exp_addr.tw_addr, twiddle_addr);
                rd_idx++;
            end else if ((rd_idx > 0) && (rd_idx < NTT_WORDS_PER_ROUND)) begin
                fail_run("Read strobes of a round are not consecutive");
            end
            // Each butterfly result is written in the cycle it arrives
            check_count("write strobe", int'(butterfly_ready), int'(mem_wr.en));
            if (mem_wr.en) begin
                if (wr_idx >= NTT_WORDS_PER_ROUND) fail_run("More than 64 writes in one round");
                exp_addr = ref_addrs(cur_round, wr_idx, base_addr);
                check_addr("write address", exp_addr.wr_addr, mem_wr.addr);
                wr_idx++;
                wr_total++;
            end
            // Round closes once both sides have seen all 64 words
            if ((rd_idx == NTT_WORDS_PER_ROUND) && (wr_idx == NTT_WORDS_PER_ROUND)) begin
                rd_idx    = 0;
                wr_idx    = 0;
                cur_round = cur_round + round_t'(1);
            end
            if (done) begin
                check_round("rounds at done", round_t'(NTT_NUM_ROUNDS), cur_round);
                check_count("writes at done", NTT_NUM_ROUNDS * NTT_WORDS_PER_ROUND, wr_total);
                check_count("busy at done", 0, int'(busy));
                done_count++;
            end
        end
    end

    // ----------------------------------------
    // Test sequences
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic start_run(input ntt_base_addr_t bases);
        check_count("busy before start", 0, int'(busy));
        base_addr    = bases;
        expect_quiet = 1'b0;
        ntt_enable   = 1'b1;
        next_cycle();
        ntt_enable   = 1'b0;
    endtask

    task automatic run_ntt(input string name, input ntt_base_addr_t bases, input logic extra_start);
        test_name = name;
        start_run(bases);
        if (extra_start) begin
            // Second strobe in the middle of round 1
            while ((cur_round != 3'd1) || (rd_idx < 10)) next_cycle();
            ntt_enable = 1'b1;
            next_cycle();
            ntt_enable = 1'b0;
        end
        while (done_count == 0) next_cycle();
        repeat (3) next_cycle();
        check_count("done pulses", 1, done_count);
        check_count("busy after done", 0, int'(busy));
    endtask

    task automatic zeroize_mid_run(input ntt_base_addr_t bases);
        test_name = "zeroize";
        start_run(bases);
        // Cut in during round 1 with butterfly results still pending
        while ((cur_round != 3'd1) || (rd_idx < 20)) next_cycle();
        zeroize = 1'b1;
        next_cycle();
        expect_quiet = 1'b1;
        next_cycle();
        zeroize = 1'b0;
        repeat (10) next_cycle();
        check_count("busy after zeroize", 0, int'(busy));
    endtask

    initial begin : main_sequence
        reset_n         = 1'b0;
        zeroize         = 1'b0;
        ntt_enable      = 1'b0;
        butterfly_ready = 1'b0;
        base_addr       = '0;
        expect_quiet    = 1'b0;
        test_name       = "reset";
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        reset_n = 1'b1;
        check_count("busy after reset", 0, int'(busy));
        check_count("done after reset", 0, int'(done));
        run_ntt("first run", BASES_A, 1'b0);
        run_ntt("start filter", BASES_B, 1'b1);
        zeroize_mid_run(BASES_C);
        run_ntt("restart after zeroize", BASES_C, 1'b0);
        $display("All checks passed");
        $finish;
    end

endmodule

/* verilog.f */
source/ntt_ctrl_pkg.sv
source/ntt_twiddle_addr_gen.sv
source/ntt_read_seq.sv
source/ntt_write_seq.sv
source/ntt_round_ctrl.sv
source/ntt_ctrl.sv
tests/ntt_ctrl_checker.sv
tests/ntt_ctrl_tb.sv
